/* flist.f */
logic/accel_pkg.sv
logic/regmap_pkg.sv
logic/param_regs.sv
logic/mem_sp.sv
logic/img_arbiter.sv
logic/fc_engine.sv
logic/kinpira_top.sv
sim/clk_gen.sv
sim/kinpira_properties.sv
sim/kinpira_tb.sv

/* logic/accel_pkg.sv */
package accel_pkg;

  // Datapath geometry
  localparam int DWIDTH   = 16;
  localparam int WWIDTH   = 8;
  localparam int IMGSIZE  = 10;
  localparam int NETSIZE  = 10;
  localparam int LWIDTH   = 10;
  localparam int FRACBITS = 4;

  typedef logic signed [DWIDTH-1:0] data_t;
  typedef logic signed [WWIDTH-1:0] weight_t;
  typedef logic signed [31:0]       acc_t;

  typedef logic [IMGSIZE-1:0] img_addr_t;
  typedef logic [NETSIZE-1:0] net_addr_t;
  typedef logic [LWIDTH-1:0]  count_t;

  // Saturation bounds of a data word, in accumulator scale
  localparam acc_t DATA_MAX = acc_t'(2**(DWIDTH-1) - 1);
  localparam acc_t DATA_MIN = acc_t'(-(2**(DWIDTH-1)));

endpackage

/* logic/fc_engine.sv */
`timescale 1ns/1ps

module fc_engine
  ( input  logic                  clk
  , input  logic                  xrst
  , input  logic                  req
  , input  accel_pkg::img_addr_t  in_offset
  , input  accel_pkg::img_addr_t  out_offset
  , input  accel_pkg::net_addr_t  net_offset
  , input  accel_pkg::count_t     total_out
  , input  accel_pkg::count_t     total_in
  , input  accel_pkg::data_t      img_rdata
  , input  accel_pkg::weight_t    net_rdata
  , output logic                  busy
  , output logic                  img_we
  , output accel_pkg::img_addr_t  img_addr
  , output accel_pkg::data_t      img_wdata
  , output accel_pkg::net_addr_t  net_addr
  );

  import accel_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_DRAIN,
    S_WRITE
  } state_t;

  state_t    state;
  logic      req_d;
  logic      start;
  logic      issue;
  logic      last_in;
  logic      last_out;
  logic      pipe_empty;
  count_t    i_cnt;
  count_t    o_cnt;
  net_addr_t net_base;

  // Pipeline valids: memory read, then product
  logic      rd_v;
  logic      mul_v;
  acc_t      prod;
  acc_t      acc;
  acc_t      shifted;
  data_t     result;

  assign start      = req & ~req_d & (state == S_IDLE);
  assign issue      = (state == S_READ);
  assign last_in    = (i_cnt == count_t'(total_in - 1'b1));
  assign last_out   = (o_cnt == count_t'(total_out - 1'b1));
  assign pipe_empty = ~rd_v & ~mul_v;

  // Pending start counts as busy so ack drops at once
  assign busy = (state != S_IDLE) | start;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state    <= S_IDLE;
      req_d    <= 1'b0;
      i_cnt    <= '0;
      o_cnt    <= '0;
      net_base <= '0;
      rd_v     <= 1'b0;
      mul_v    <= 1'b0;
    end else begin
      req_d <= req;
      rd_v  <= issue;
      mul_v <= rd_v;
      case (state)
        S_IDLE: begin
          if (start && total_out != '0) begin
            i_cnt    <= '0;
            o_cnt    <= '0;
            net_base <= net_offset;
            state    <= (total_in == '0) ? S_DRAIN : S_READ;
          end
        end
        S_READ: begin
          if (last_in) begin
            state <= S_DRAIN;
          end else begin
            i_cnt <= i_cnt + 1'b1;
          end
        end
        S_DRAIN: begin
          if (pipe_empty) begin
            state <= S_WRITE;
          end
        end
        S_WRITE: begin
          if (last_out) begin
            state <= S_IDLE;
          end else begin
            i_cnt    <= '0;
            o_cnt    <= o_cnt + 1'b1;
            net_base <= net_addr_t'(net_base + total_in);
            state    <= (total_in == '0) ? S_DRAIN : S_READ;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Multiply one cycle after the read data lands, then accumulate
  always_ff @(posedge clk) begin
    prod <= img_rdata * net_rdata;
    if (start || state == S_WRITE) begin
      acc <= '0;
    end else if (mul_v) begin
      acc <= acc + prod;
    end
  end

  always_comb begin
    shifted = acc >>> FRACBITS;
    if (shifted > DATA_MAX) begin
      result = data_t'(DATA_MAX);
    end else if (shifted < DATA_MIN) begin
      result = data_t'(DATA_MIN);
    end else begin
      result = data_t'(shifted);
    end
  end

  // Image port carries the result write in place of a read
  assign img_we    = (state == S_WRITE);
  assign img_addr  = (state == S_WRITE) ? img_addr_t'(out_offset + o_cnt)
                   : img_addr_t'(in_offset + i_cnt);
  assign img_wdata = result;
  assign net_addr  = net_addr_t'(net_base + i_cnt);

endmodule

/* logic/img_arbiter.sv */
`timescale 1ns/1ps

module img_arbiter
  ( input  regmap_pkg::which_t    which
  , input  logic                  req
  , input  logic                  host_we
  , input  accel_pkg::img_addr_t  host_addr
  , input  accel_pkg::data_t      host_wdata
  , input  logic                  fc_busy
  , input  logic                  fc_we
  , input  accel_pkg::img_addr_t  fc_addr
  , input  accel_pkg::data_t      fc_wdata
  , output logic                  fc_req
  , output logic                  mem_we
  , output accel_pkg::img_addr_t  mem_addr
  , output accel_pkg::data_t      mem_wdata
  , output logic                  ack
  );

  import regmap_pkg::*;

  logic sel_host;
  logic sel_fc;

  always_comb begin
    sel_host = 1'b0;
    sel_fc   = 1'b0;
    ack      = 1'b0;
    case (which)
      WHICH_HOST: begin
        sel_host = 1'b1;
        ack      = 1'b1;
      end
      WHICH_FC: begin
        sel_fc = 1'b1;
        ack    = ~fc_busy;
      end
      // Reserved code and code 3 select no master
      default: ;
    endcase
  end

  assign fc_req = sel_fc & req;

  assign mem_we    = (sel_host & host_we) | (sel_fc & fc_we);
  assign mem_addr  = sel_fc ? fc_addr
                   : sel_host ? host_addr
                   : '0;
  assign mem_wdata = sel_fc ? fc_wdata
                   : sel_host ? host_wdata
                   : '0;

endmodule

/* logic/kinpira_top.sv */
`timescale 1ns/1ps

module kinpira_top
  ( input  logic                  clk
  , input  logic                  xrst
  , input  logic                  reg_we
  , input  logic                  reg_re
  , input  regmap_pkg::reg_idx_t  reg_addr
  , input  logic [31:0]           reg_wdata
  , output logic [31:0]           reg_rdata
  , output logic                  reg_rvalid
  , input  logic                  img_we
  , input  accel_pkg::img_addr_t  img_addr
  , input  accel_pkg::data_t      img_wdata
  , output accel_pkg::data_t      img_rdata
  , input  logic                  net_we
  , input  accel_pkg::net_addr_t  net_addr
  , input  accel_pkg::weight_t    net_wdata
  );

  import accel_pkg::*;
  import regmap_pkg::*;

  which_t    which;
  logic      req;
  img_addr_t in_offset;
  img_addr_t out_offset;
  net_addr_t net_offset;
  count_t    total_out;
  count_t    total_in;
  logic      ack;

  logic      fc_req;
  logic      fc_busy;
  logic      fc_we;
  img_addr_t fc_addr;
  data_t     fc_wdata;
  net_addr_t fc_net_addr;

  logic      mem_we;
  img_addr_t mem_addr;
  data_t     mem_wdata;
  net_addr_t wmem_addr;
  weight_t   net_rdata;

  param_regs regs0 (
    .clk        (clk),
    .xrst       (xrst),
    .reg_we     (reg_we),
    .reg_re     (reg_re),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .ack        (ack),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .which      (which),
    .req        (req),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_out  (total_out),
    .total_in   (total_in)
  );

  img_arbiter arb0 (
    .which      (which),
    .req        (req),
    .host_we    (img_we),
    .host_addr  (img_addr),
    .host_wdata (img_wdata),
    .fc_busy    (fc_busy),
    .fc_we      (fc_we),
    .fc_addr    (fc_addr),
    .fc_wdata   (fc_wdata),
    .fc_req     (fc_req),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .ack        (ack)
  );

  mem_sp #(.word_t(data_t), .AWIDTH(IMGSIZE)) mem_img (
    .clk   (clk),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (img_rdata)
  );

  // Host weight writes take the port, the engine reads otherwise
  assign wmem_addr = net_we ? net_addr : fc_net_addr;

  mem_sp #(.word_t(weight_t), .AWIDTH(NETSIZE)) mem_net (
    .clk   (clk),
    .we    (net_we),
    .addr  (wmem_addr),
    .wdata (net_wdata),
    .rdata (net_rdata)
  );

  fc_engine fc0 (
    .clk        (clk),
    .xrst       (xrst),
    .req        (fc_req),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_out  (total_out),
    .total_in   (total_in),
    .img_rdata  (img_rdata),
    .net_rdata  (net_rdata),
    .busy       (fc_busy),
    .img_we     (fc_we),
    .img_addr   (fc_addr),
    .img_wdata  (fc_wdata),
    .net_addr   (fc_net_addr)
  );

endmodule

/* logic/mem_sp.sv */
`timescale 1ns/1ps

module mem_sp
 #( parameter type word_t = logic [7:0]
  , parameter int  AWIDTH = 10
  )
  ( input  logic              clk
  , input  logic              we
  , input  logic [AWIDTH-1:0] addr
  , input  word_t             wdata
  , output word_t             rdata
  );

  word_t mem [2**AWIDTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Read returns the word held before a same-cycle write
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

/* logic/param_regs.sv */
`timescale 1ns/1ps

module param_regs
  ( input  logic                  clk
  , input  logic                  xrst
  , input  logic                  reg_we
  , input  logic                  reg_re
  , input  regmap_pkg::reg_idx_t  reg_addr
  , input  logic [31:0]           reg_wdata
  , input  logic                  ack
  , output logic [31:0]           reg_rdata
  , output logic                  reg_rvalid
  , output regmap_pkg::which_t    which
  , output logic                  req
  , output accel_pkg::img_addr_t  in_offset
  , output accel_pkg::img_addr_t  out_offset
  , output accel_pkg::net_addr_t  net_offset
  , output accel_pkg::count_t     total_out
  , output accel_pkg::count_t     total_in
  );

  import accel_pkg::*;
  import regmap_pkg::*;

  which_t      which_rd;
  logic [31:0] rd_word;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      which      <= WHICH_HOST;
      req        <= 1'b0;
      in_offset  <= '0;
      out_offset <= '0;
      net_offset <= '0;
      total_out  <= '0;
      total_in   <= '0;
    end else if (reg_we) begin
      case (reg_addr)
        REG_WHICH:      which      <= which_t'(reg_wdata);
        REG_REQ:        req        <= reg_wdata[0];
        REG_IN_OFFSET:  in_offset  <= img_addr_t'(reg_wdata);
        REG_OUT_OFFSET: out_offset <= img_addr_t'(reg_wdata);
        REG_NET_OFFSET: net_offset <= net_addr_t'(reg_wdata);
        REG_TOTAL_OUT:  total_out  <= count_t'(reg_wdata);
        REG_TOTAL_IN:   total_in   <= count_t'(reg_wdata);
        default: ;
      endcase
    end
  end

  // Owner code seen one cycle late
  always_ff @(posedge clk) begin
    if (!xrst) begin
      which_rd   <= WHICH_HOST;
      reg_rvalid <= 1'b0;
    end else begin
      which_rd   <= which;
      reg_rvalid <= reg_re;
    end
  end

  always_comb begin
    case (reg_addr)
      REG_WHICH:      rd_word = 32'(which);
      REG_REQ:        rd_word = 32'(req);
      REG_IN_OFFSET:  rd_word = 32'(in_offset);
      REG_OUT_OFFSET: rd_word = 32'(out_offset);
      REG_NET_OFFSET: rd_word = 32'(net_offset);
      REG_TOTAL_OUT:  rd_word = 32'(total_out);
      REG_TOTAL_IN:   rd_word = 32'(total_in);
      REG_ACK:        rd_word = 32'(ack);
      REG_WHICH_RD:   rd_word = 32'(which_rd);
      default:        rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reg_re) begin
      reg_rdata <= rd_word;
    end
  end

endmodule

/* logic/regmap_pkg.sv */
package regmap_pkg;

  localparam int REGSIZE = 5;

  typedef logic [REGSIZE-1:0] reg_idx_t;

  // Writable parameters
  localparam reg_idx_t REG_WHICH      = reg_idx_t'(0);
  localparam reg_idx_t REG_REQ        = reg_idx_t'(1);
  localparam reg_idx_t REG_IN_OFFSET  = reg_idx_t'(2);
  localparam reg_idx_t REG_OUT_OFFSET = reg_idx_t'(3);
  localparam reg_idx_t REG_NET_OFFSET = reg_idx_t'(4);
  localparam reg_idx_t REG_TOTAL_OUT  = reg_idx_t'(5);
  localparam reg_idx_t REG_TOTAL_IN   = reg_idx_t'(6);

  // Status, read only
  localparam reg_idx_t REG_ACK      = reg_idx_t'(30);
  localparam reg_idx_t REG_WHICH_RD = reg_idx_t'(31);

  typedef logic [1:0] which_t;

  localparam which_t WHICH_HOST = which_t'(0);
  localparam which_t WHICH_CONV = which_t'(1);
  localparam which_t WHICH_FC   = which_t'(2);

endpackage

/* sim/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen
 #( parameter time PERIOD     = 40ns
  , parameter int  RST_CYCLES = 2
  )
  ( output logic clk
  , output logic xrst
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release on a rising edge, like any synchronous input
  initial begin
    xrst = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    xrst <= 1'b1;
  end

endmodule

/* sim/kinpira_properties.sv */
`timescale 1ns/1ps

module kinpira_properties
  ( input logic               clk
  , input logic               xrst
  , input logic               reg_re
  , input logic               reg_rvalid
  , input regmap_pkg::which_t which
  , input logic               mem_we
  , input logic               ack
  );

  import regmap_pkg::*;

  int unsigned fail_count = 0;

  // Read data valid exactly one cycle after the read strobe
  rvalid_follows_re: assert property (
    @(posedge clk) disable iff (!xrst) reg_rvalid == $past(reg_re)
  ) else begin
    $error("reg_rvalid does not follow reg_re by one cycle");
    fail_count++;
  end

  // Only host or engine may write the image memory
  we_needs_owner: assert property (
    @(posedge clk) disable iff (!xrst)
      mem_we |-> (which == WHICH_HOST || which == WHICH_FC)
  ) else begin
    $error("image memory written with no master selected");
    fail_count++;
  end

  host_ack: assert property (
    @(posedge clk) disable iff (!xrst) (which == WHICH_HOST) |-> ack
  ) else begin
    $error("ack low while the host owns the image memory");
    fail_count++;
  end

endmodule

/* sim/kinpira_tb.sv */
`timescale 1ns/1ps

module kinpira_tb;

  import accel_pkg::*;
  import regmap_pkg::*;

  logic        clk;
  logic        xrst;
  logic        reg_we;
  logic        reg_re;
  reg_idx_t    reg_addr;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic        reg_rvalid;
  logic        img_we;
  img_addr_t   img_addr;
  data_t       img_wdata;
  data_t       img_rdata;
  logic        net_we;
  net_addr_t   net_addr;
  weight_t     net_wdata;

  // Host-side copies of both memories
  data_t       img_model [2**IMGSIZE];
  weight_t     net_model [2**NETSIZE];

  int          seed = 31099;
  img_addr_t   in_off  = 10'h040;
  img_addr_t   out_off = 10'h100;
  net_addr_t   net_off = 10'h020;
  int          n_in    = 8;
  int          n_out   = 6;

  clk_gen #(.PERIOD(40ns), .RST_CYCLES(2)) clk0 (.clk(clk), .xrst(xrst));

  kinpira_top dut0 (
    .clk        (clk),
    .xrst       (xrst),
    .reg_we     (reg_we),
    .reg_re     (reg_re),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .img_we     (img_we),
    .img_addr   (img_addr),
    .img_wdata  (img_wdata),
    .img_rdata  (img_rdata),
    .net_we     (net_we),
    .net_addr   (net_addr),
    .net_wdata  (net_wdata)
  );

  bind img_arbiter kinpira_properties props0 (
    .clk        (kinpira_tb.clk),
    .xrst       (kinpira_tb.xrst),
    .reg_re     (kinpira_tb.reg_re),
    .reg_rvalid (kinpira_tb.reg_rvalid),
    .which      (which),
    .mem_we     (mem_we),
    .ack        (ack)
  );

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected=0x%h actual=0x%h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic write_reg(input reg_idx_t idx, input logic [31:0] val);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= idx;
    reg_wdata <= val;
    @(posedge clk);
    reg_we <= 1'b0;
  endtask

  task automatic read_reg(input reg_idx_t idx, output logic [31:0] val);
    int waited;
    @(posedge clk);
    reg_re   <= 1'b1;
    reg_addr <= idx;
    @(posedge clk);
    reg_re <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!reg_rvalid && waited < 8);
    if (!reg_rvalid) begin
      $display("Timeout: no read data came back for register %0d", idx);
      abort_run();
    end
    val = reg_rdata;
  endtask

  task automatic expect_reg(input reg_idx_t idx, input logic [31:0] exp);
    logic [31:0] val;
    read_reg(idx, val);
    check_word($sformatf("reg_rdata[%0d]", idx), exp, val);
  endtask

  task automatic write_img(input img_addr_t a, input data_t d);
    @(posedge clk);
    img_we    <= 1'b1;
    img_addr  <= a;
    img_wdata <= d;
    @(posedge clk);
    img_we <= 1'b0;
  endtask

  // Read data is registered, so it lands one cycle after the address
  task automatic expect_img(input img_addr_t a, input data_t exp);
    @(posedge clk);
    img_addr <= a;
    @(posedge clk);
    @(negedge clk);
    check_data($sformatf("img_rdata[0x%h]", a), exp, img_rdata);
  endtask

  task automatic write_net(input net_addr_t a, input weight_t w);
    @(posedge clk);
    net_we    <= 1'b1;
    net_addr  <= a;
    net_wdata <= w;
    net_model[a] = w;
    @(posedge clk);
    net_we <= 1'b0;
  endtask

  function automatic data_t fc_ref(input int o);
    longint sum;
    longint scaled;
    longint hi;
    longint lo;
    int     i;
    sum = 0;
    hi  = (longint'(1) <<< (DWIDTH - 1)) - 1;
    lo  = -(longint'(1) <<< (DWIDTH - 1));
    for (i = 0; i < n_in; i++) begin
      sum += longint'(img_model[in_off + i]) * longint'(net_model[net_off + o * n_in + i]);
    end
    scaled = sum >>> FRACBITS;
    if (scaled > hi) scaled = hi;
    if (scaled < lo) scaled = lo;
    return data_t'(scaled);
  endfunction

  task automatic wait_engine_done();
    logic [31:0] val;
    int polls;
    val   = '0;
    polls = 0;
    while (val !== 32'd1 && polls < 200) begin
      read_reg(REG_ACK, val);
      polls++;
    end
    if (val !== 32'd1) begin
      $display("Timeout: engine ack still low after %0d polls", polls);
      abort_run();
    end
  endtask

  initial begin
    int          k;
    int          w;
    img_addr_t   a;
    data_t       d;
    logic [31:0] v;
    logic [31:0] saved [2:6];
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    img_we    = 1'b0;
    img_addr  = '0;
    img_wdata = '0;
    net_we    = 1'b0;
    net_addr  = '0;
    net_wdata = '0;

    k = 0;
    while (xrst !== 1'b1 && k < 10) begin
      @(negedge clk);
      k++;
    end
    if (xrst !== 1'b1) begin
      $display("Timeout: reset was never released");
      abort_run();
    end

    // Ack reads 1 after reset since the host owns memory
    for (k = 0; k < 32; k++) begin
      expect_reg(reg_idx_t'(k), (reg_idx_t'(k) == REG_ACK) ? 32'd1 : 32'd0);
    end

    for (k = 2; k <= 6; k++) begin
      v = $random(seed);
      saved[k] = {22'd0, v[9:0]};
      write_reg(reg_idx_t'(k), v);
      expect_reg(reg_idx_t'(k), saved[k]);
    end
    write_reg(REG_WHICH, 32'(WHICH_FC));
    expect_reg(REG_WHICH, 32'(WHICH_FC));
    expect_reg(REG_WHICH_RD, 32'(WHICH_FC));
    write_reg(REG_ACK, $random(seed));
    write_reg(REG_WHICH_RD, $random(seed));
    expect_reg(REG_ACK, 32'd1);
    expect_reg(REG_WHICH_RD, 32'(WHICH_FC));
    expect_reg(REG_WHICH, 32'(WHICH_FC));
    for (k = 2; k <= 6; k++) begin
      expect_reg(reg_idx_t'(k), saved[k]);
    end

    // Host writes land only under host ownership
    write_reg(REG_WHICH, 32'(WHICH_HOST));
    for (k = 0; k < 16; k++) begin
      a = img_addr_t'(10'h200 + k);
      d = data_t'($random(seed));
      img_model[a] = d;
      write_img(a, d);
    end
    for (k = 0; k < 16; k++) begin
      expect_img(img_addr_t'(10'h200 + k), img_model[10'h200 + k]);
    end
    write_reg(REG_WHICH, 32'(WHICH_FC));
    write_img(img_addr_t'(10'h205), ~img_model[10'h205]);
    write_reg(REG_WHICH, 32'(WHICH_HOST));
    expect_img(img_addr_t'(10'h205), img_model[10'h205]);

    // Two huge inputs drive outputs 0 and 1 into saturation
    for (k = 0; k < n_in; k++) begin
      if (k == 0) d = 16'sh7fff;
      else if (k == 1) d = -16'sh8000;
      else d = data_t'($random(seed)) >>> 5;
      img_model[in_off + k] = d;
      write_img(img_addr_t'(in_off + k), d);
    end
    for (k = 0; k < n_out; k++) begin
      for (w = 0; w < n_in; w++) begin
        if (k == 0) d = (w == 0) ? 16'sd127 : (w == 1) ? -16'sd128 : 16'sd0;
        else if (k == 1) d = (w == 0) ? -16'sd128 : (w == 1) ? 16'sd127 : 16'sd0;
        else d = (w < 2) ? 16'sd0 : data_t'(weight_t'($random(seed)));
        write_net(net_addr_t'(net_off + k * n_in + w), weight_t'(d));
      end
    end
    write_reg(REG_IN_OFFSET, 32'(in_off));
    write_reg(REG_OUT_OFFSET, 32'(out_off));
    write_reg(REG_NET_OFFSET, 32'(net_off));
    write_reg(REG_TOTAL_OUT, n_out);
    write_reg(REG_TOTAL_IN, n_in);
    write_reg(REG_REQ, 32'd0);
    write_reg(REG_WHICH, 32'(WHICH_FC));
    write_reg(REG_REQ, 32'd1);
    expect_reg(REG_ACK, 32'd0);
    wait_engine_done();
    write_reg(REG_REQ, 32'd0);
    write_reg(REG_WHICH, 32'(WHICH_HOST));
    for (k = 0; k < n_out; k++) begin
      img_model[out_off + k] = fc_ref(k);
      expect_img(img_addr_t'(out_off + k), img_model[out_off + k]);
    end

    // Reserved owner starts nothing and touches no memory
    write_reg(REG_WHICH, 32'(WHICH_CONV));
    write_img(in_off, ~img_model[in_off]);
    write_reg(REG_REQ, 32'd1);
    expect_reg(REG_ACK, 32'd0);
    write_reg(REG_REQ, 32'd0);
    // An engine started under the reserved owner would still be busy here
    write_reg(REG_WHICH, 32'(WHICH_FC));
    expect_reg(REG_ACK, 32'd1);
    write_reg(REG_WHICH, 32'(WHICH_HOST));
    for (k = 0; k < n_in; k++) begin
      expect_img(img_addr_t'(in_off + k), img_model[in_off + k]);
    end
    for (k = 0; k < n_out; k++) begin
      expect_img(img_addr_t'(out_off + k), img_model[out_off + k]);
    end

    @(posedge clk);
    if (dut0.arb0.props0.fail_count != 0) begin
      $display("Bound assertions failed %0d times", dut0.arb0.props0.fail_count);
      abort_run();
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule
